// File: build.f
+incdir+include
rtl/rvc_pkg.sv
rtl/rvc_classifier.sv
rtl/rvc_reg_mapper.sv
rtl/rvc_imm_builder.sv
rtl/rvc_instr_assembler.sv
rtl/rvc_decompressor.sv
tb/tb_rvc_decompressor.sv

// File: include/rvc_config.svh
// ------------------------------------------------
// Widths, register numbers and field positions
// Shared by the package, the RTL and the testbench
// ------------------------------------------------
`ifndef RVC_CONFIG_SVH
`define RVC_CONFIG_SVH

`define RVC_ILEN        16      // Compressed instruction width
`define RV_ILEN         32      // Base instruction width
`define RV_REG_W        5       // Register index width

`define RV_REG_RA       5'd1    // Link register
`define RV_REG_SP       5'd2    // Stack pointer
`define RVC_RPRIME_BASE 2'b01   // Prefix for x8..x15

// Compressed field
`define RVC_F3_LSB      13

// Base instruction fields
`define RV_RD_LSB       7
`define RV_F3_LSB       12
`define RV_RS1_LSB      15
`define RV_RS2_LSB      20
`define RV_F12_LSB      20
`define RV_F7_LSB       25

`endif

// File: rtl/rvc_classifier.sv
// ------------------------------------------------
// Picks the compressed instruction and flags reserved encodings
// Quadrant 3 and all floating-point forms are illegal
// ------------------------------------------------
`default_nettype none

`include "rvc_config.svh"

module rvc_classifier (
    input  rvc_pkg::rvc_instr16_t ci_instr16_i,
    output rvc_pkg::rvc_dec_t     dec_o
);
    import rvc_pkg::*;

    logic [1:0] quad;
    logic [2:0] funct3;
    logic       bit12;
    logic       hi5_zero;   // Bits 11:7 clear
    logic       lo5_zero;   // Bits 6:2 clear

    assign quad     = ci_instr16_i[1:0];
    assign funct3   = ci_instr16_i[`RVC_F3_LSB +: 3];
    assign bit12    = ci_instr16_i[12];
    assign hi5_zero = (ci_instr16_i[11:7] == '0);
    assign lo5_zero = (ci_instr16_i[6:2] == '0);

    always_comb begin
        dec_o.op      = RVC_ILLEGAL;
        dec_o.illegal = 1'b0;
        unique case (quad)
            // ------------------------------------------------
            2'b00: begin
                unique case (funct3)
                    3'b000: begin
                        dec_o.op      = RVC_ADDI4SPN;
                        dec_o.illegal = (ci_instr16_i[12:5] == '0); // Includes the all-zero word
                    end
                    3'b010:  dec_o.op = RVC_LW;
                    3'b110:  dec_o.op = RVC_SW;
                    default: dec_o.illegal = 1'b1; // FLW, FSW and reserved slots
                endcase
            end
            // ------------------------------------------------
            2'b01: begin
                unique case (funct3)
                    3'b000: dec_o.op = RVC_ADDI;   // NOP when rd is x0
                    3'b001: dec_o.op = RVC_JAL;
                    3'b010: dec_o.op = RVC_LI;
                    3'b011: begin
                        dec_o.op = (ci_instr16_i[11:7] == `RV_REG_SP) ? RVC_ADDI16SP : RVC_LUI;
                        dec_o.illegal = !bit12 && lo5_zero;  // Zero immediate reserved
                    end
                    3'b100: begin
                        unique case (ci_instr16_i[11:10])
                            2'b00: dec_o.op = RVC_SRLI;
                            2'b01: dec_o.op = RVC_SRAI;
                            2'b10: dec_o.op = RVC_ANDI;
                            default: begin
                                unique case (ci_instr16_i[6:5])
                                    2'b00:   dec_o.op = RVC_SUB;
                                    2'b01:   dec_o.op = RVC_XOR;
                                    2'b10:   dec_o.op = RVC_OR;
                                    default: dec_o.op = RVC_AND;
                                endcase
                            end
                        endcase
                        // shamt[5] on shifts, RV64 forms on the ALU ops
                        dec_o.illegal = bit12 && (ci_instr16_i[11:10] != 2'b10);
                    end
                    3'b101:  dec_o.op = RVC_J;
                    3'b110:  dec_o.op = RVC_BEQZ;
                    default: dec_o.op = RVC_BNEZ;
                endcase
            end
            // ------------------------------------------------
            2'b10: begin
                unique case (funct3)
                    3'b000: begin
                        dec_o.op      = RVC_SLLI;
                        dec_o.illegal = bit12;
                    end
                    3'b010: dec_o.op = RVC_LWSP;
                    3'b100: begin
                        if (!bit12) begin
                            dec_o.op = lo5_zero ? RVC_JR : RVC_MV;
                        end else if (!lo5_zero) begin
                            dec_o.op = RVC_ADD;
                        end else begin
                            dec_o.op = hi5_zero ? RVC_EBREAK : RVC_JALR;
                        end
                    end
                    3'b110:  dec_o.op = RVC_SWSP;
                    default: dec_o.illegal = 1'b1; // FLWSP, FSWSP, FLDSP, FSDSP
                endcase
            end
            default: dec_o.illegal = 1'b1; // 32-bit encoding space
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/rvc_decompressor.sv
// ------------------------------------------------
// RV32C expander stage with one cycle of latency
// No back-pressure, so every result must be taken
// ------------------------------------------------
`default_nettype none

module rvc_decompressor (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  ci_valid_i,
    input  rvc_pkg::rvc_instr16_t ci_instr16_i,
    output logic                  ci_valid_o,
    output logic                  ci_illegal_o,
    output rvc_pkg::rv_instr32_t  ci_instr32_o
);
    import rvc_pkg::*;

    rvc_dec_t    dec;
    rv_regs_t    regs;
    rv_instr32_t imm;

    rvc_classifier u_classifier (
        .ci_instr16_i (ci_instr16_i),
        .dec_o        (dec)
    );

    rvc_reg_mapper u_reg_mapper (
        .ci_instr16_i (ci_instr16_i),
        .op_i         (dec.op),
        .regs_o       (regs)
    );

    rvc_imm_builder u_imm_builder (
        .ci_instr16_i (ci_instr16_i),
        .op_i         (dec.op),
        .imm_o        (imm)
    );

    rvc_instr_assembler u_instr_assembler (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .valid_i   (ci_valid_i),
        .dec_i     (dec),
        .regs_i    (regs),
        .imm_i     (imm),
        .valid_o   (ci_valid_o),
        .illegal_o (ci_illegal_o),
        .instr32_o (ci_instr32_o)
    );

endmodule

`default_nettype wire

// File: rtl/rvc_imm_builder.sv
// ------------------------------------------------
// Immediate image in final 32-bit positions
// All bits outside the immediate fields are zero
// ------------------------------------------------
`default_nettype none

module rvc_imm_builder (
    input  rvc_pkg::rvc_instr16_t ci_instr16_i,
    input  rvc_pkg::rvc_op_e      op_i,
    output rvc_pkg::rv_instr32_t  imm_o
);
    import rvc_pkg::*;

    rvc_instr16_t c;
    logic [11:0]  imm6_sx;       // Sign-extended 6-bit value
    logic [11:0]  addi4spn_off;
    logic [11:0]  addi16sp_off;
    logic [11:0]  mem_w_off;     // LW and SW
    logic [11:0]  lwsp_off;
    logic [11:0]  swsp_off;
    logic [12:0]  br_off;
    logic [20:0]  jal_off;

    // Format scatter helpers
    function automatic rv_instr32_t fmt_i(input logic [11:0] imm);
        fmt_i = {imm, 20'b0};
    endfunction

    function automatic rv_instr32_t fmt_s(input logic [11:0] imm);
        fmt_s = {imm[11:5], 13'b0, imm[4:0], 7'b0};
    endfunction

    function automatic rv_instr32_t fmt_b(input logic [12:0] imm);
        fmt_b = {imm[12], imm[10:5], 13'b0, imm[4:1], imm[11], 7'b0};
    endfunction

    function automatic rv_instr32_t fmt_j(input logic [20:0] imm);
        fmt_j = {imm[20], imm[10:1], imm[11], imm[19:12], 12'b0};
    endfunction

    assign c = ci_instr16_i;

    // Offsets in bytes
    assign imm6_sx      = {{6{c[12]}}, c[12], c[6:2]};
    assign addi4spn_off = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00};
    assign addi16sp_off = {{2{c[12]}}, c[12], c[4:3], c[5], c[2], c[6], 4'b0000};
    assign mem_w_off    = {5'b0, c[5], c[12:10], c[6], 2'b00};
    assign lwsp_off     = {4'b0, c[3:2], c[12], c[6:4], 2'b00};
    assign swsp_off     = {4'b0, c[8:7], c[12:9], 2'b00};
    assign br_off       = {{4{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};
    assign jal_off      = {{9{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11],
                           c[5:3], 1'b0};

    always_comb begin
        unique case (op_i)
            RVC_ADDI4SPN:                 imm_o = fmt_i(addi4spn_off);
            RVC_LW:                       imm_o = fmt_i(mem_w_off);
            RVC_SW:                       imm_o = fmt_s(mem_w_off);
            RVC_ADDI, RVC_LI, RVC_ANDI:   imm_o = fmt_i(imm6_sx);
            RVC_ADDI16SP:                 imm_o = fmt_i(addi16sp_off);
            RVC_LUI:                      imm_o = {{14{c[12]}}, c[12], c[6:2], 12'b0};
            RVC_SRLI, RVC_SRAI, RVC_SLLI: imm_o = fmt_i({7'b0, c[6:2]}); // shamt at 24:20
            RVC_JAL, RVC_J:               imm_o = fmt_j(jal_off);
            RVC_BEQZ, RVC_BNEZ:           imm_o = fmt_b(br_off);
            RVC_LWSP:                     imm_o = fmt_i(lwsp_off);
            RVC_SWSP:                     imm_o = fmt_s(swsp_off);
            default:                      imm_o = '0;  // Register forms and EBREAK
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/rvc_instr_assembler.sv
// ------------------------------------------------
// Adds opcode and function fields, then registers
// Word is unspecified whenever illegal_o is set
// ------------------------------------------------
`default_nettype none

`include "rvc_config.svh"

module rvc_instr_assembler (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 valid_i,
    input  rvc_pkg::rvc_dec_t    dec_i,
    input  rvc_pkg::rv_regs_t    regs_i,
    input  rvc_pkg::rv_instr32_t imm_i,
    output logic                 valid_o,
    output logic                 illegal_o,
    output rvc_pkg::rv_instr32_t instr32_o
);
    import rvc_pkg::*;

    rv_opcode_e  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] funct12;
    logic        use_rd;
    logic        use_rs1;
    logic        use_rs2;
    rv_instr32_t instr_d;

    // Field selection per op
    // ------------------------------------------------
    always_comb begin
        opcode  = OPC_OP_IMM;
        funct3  = F3_ADD;      // Also JALR funct3
        funct7  = F7_ZERO;
        funct12 = '0;
        use_rd  = 1'b1;
        use_rs1 = 1'b1;
        use_rs2 = 1'b0;
        unique case (dec_i.op)
            RVC_LW, RVC_LWSP: begin
                opcode = OPC_LOAD;
                funct3 = F3_W;
            end
            RVC_SW, RVC_SWSP: begin
                opcode  = OPC_STORE;
                funct3  = F3_W;
                use_rd  = 1'b0;
                use_rs2 = 1'b1;
            end
            RVC_JAL, RVC_J, RVC_LUI: begin
                opcode  = (dec_i.op == RVC_LUI) ? OPC_LUI : OPC_JAL;
                use_rs1 = 1'b0;
            end
            RVC_JR, RVC_JALR: opcode = OPC_JALR;
            RVC_SRLI:         funct3 = F3_SR;
            RVC_SRAI: begin
                funct3 = F3_SR;
                funct7 = F7_ALT;
            end
            RVC_SLLI: funct3 = F3_SLL;
            RVC_ANDI: funct3 = F3_AND;
            RVC_SUB, RVC_XOR, RVC_OR, RVC_AND, RVC_MV, RVC_ADD: begin
                opcode  = OPC_OP;
                use_rs2 = 1'b1;
                if (dec_i.op == RVC_SUB) funct7 = F7_ALT;
                if (dec_i.op == RVC_XOR) funct3 = F3_XOR;
                if (dec_i.op == RVC_OR)  funct3 = F3_OR;
                if (dec_i.op == RVC_AND) funct3 = F3_AND;
            end
            RVC_BEQZ, RVC_BNEZ: begin
                opcode  = OPC_BRANCH;
                funct3  = (dec_i.op == RVC_BNEZ) ? F3_BNE : F3_BEQ;
                use_rd  = 1'b0;
                use_rs2 = 1'b1;
            end
            RVC_EBREAK: begin
                opcode  = OPC_SYSTEM;
                funct12 = F12_EBREAK;
                use_rd  = 1'b0;
                use_rs1 = 1'b0;
            end
            default: opcode = OPC_OP_IMM;  // ADDI4SPN, ADDI, LI, ADDI16SP, illegal
        endcase
    end

    // Merge into the immediate image
    always_comb begin
        instr_d                     = imm_i;
        instr_d[6:0]                = opcode;
        instr_d[`RV_F3_LSB +: 3]   |= funct3;
        instr_d[`RV_F7_LSB +: 7]   |= funct7;
        instr_d[`RV_F12_LSB +: 12] |= funct12;
        if (use_rd)  instr_d[`RV_RD_LSB +: `RV_REG_W]  = regs_i.rd;
        if (use_rs1) instr_d[`RV_RS1_LSB +: `RV_REG_W] = regs_i.rs1;
        if (use_rs2) instr_d[`RV_RS2_LSB +: `RV_REG_W] = regs_i.rs2;
    end

    // Output stage
    // ------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o   <= 1'b0;
            illegal_o <= 1'b0;
            instr32_o <= '0;
        end else begin
            valid_o <= valid_i;    // Low input cycle gives a low output cycle
            if (valid_i) begin
                illegal_o <= dec_i.illegal;
                instr32_o <= instr_d;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/rvc_pkg.sv
// ------------------------------------------------
// Types and function codes for the RV32C expander
// Only integer compressed forms are enumerated
// ------------------------------------------------
`default_nettype none

`include "rvc_config.svh"

package rvc_pkg;

    typedef logic [`RVC_ILEN-1:0] rvc_instr16_t;
    typedef logic [`RV_ILEN-1:0]  rv_instr32_t;

    // One entry per compressed instruction
    typedef enum logic [4:0] {
        RVC_ADDI4SPN, RVC_LW,   RVC_SW,
        RVC_ADDI,     RVC_JAL,  RVC_LI,    RVC_ADDI16SP, RVC_LUI,
        RVC_SRLI,     RVC_SRAI, RVC_ANDI,
        RVC_SUB,      RVC_XOR,  RVC_OR,    RVC_AND,
        RVC_J,        RVC_BEQZ, RVC_BNEZ,
        RVC_SLLI,     RVC_LWSP, RVC_SWSP,
        RVC_JR,       RVC_MV,   RVC_EBREAK, RVC_JALR,    RVC_ADD,
        RVC_ILLEGAL
    } rvc_op_e;

    // Base opcodes
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } rv_opcode_e;

    typedef struct packed {
        logic [`RV_REG_W-1:0] rd;
        logic [`RV_REG_W-1:0] rs1;
        logic [`RV_REG_W-1:0] rs2;
    } rv_regs_t;

    typedef struct packed {
        rvc_op_e op;
        logic    illegal;
    } rvc_dec_t;

    // funct3
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_W   = 3'b010;    // LW and SW
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SR  = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // funct7 and funct12
    localparam logic [6:0]  F7_ZERO    = 7'b0000000;
    localparam logic [6:0]  F7_ALT     = 7'b0100000;  // SUB and SRAI
    localparam logic [11:0] F12_EBREAK = 12'h001;

endpackage

`default_nettype wire

// File: rtl/rvc_reg_mapper.sv
// ------------------------------------------------
// Register index expansion per compressed op
// Registers a format lacks come out as x0
// ------------------------------------------------
`default_nettype none

`include "rvc_config.svh"

module rvc_reg_mapper (
    input  rvc_pkg::rvc_instr16_t ci_instr16_i,
    input  rvc_pkg::rvc_op_e      op_i,
    output rvc_pkg::rv_regs_t     regs_o
);
    import rvc_pkg::*;

    logic [`RV_REG_W-1:0] rp_hi;   // rs1'/rd' at 9:7
    logic [`RV_REG_W-1:0] rp_lo;   // rs2'/rd' at 4:2
    logic [`RV_REG_W-1:0] r_hi;
    logic [`RV_REG_W-1:0] r_lo;

    assign rp_hi = {`RVC_RPRIME_BASE, ci_instr16_i[9:7]};
    assign rp_lo = {`RVC_RPRIME_BASE, ci_instr16_i[4:2]};
    assign r_hi  = ci_instr16_i[11:7];
    assign r_lo  = ci_instr16_i[6:2];

    always_comb begin
        regs_o = '0;
        unique case (op_i)
            RVC_ADDI4SPN: begin
                regs_o.rd  = rp_lo;
                regs_o.rs1 = `RV_REG_SP;
            end
            RVC_LW: begin
                regs_o.rd  = rp_lo;
                regs_o.rs1 = rp_hi;
            end
            RVC_SW: begin
                regs_o.rs1 = rp_hi;
                regs_o.rs2 = rp_lo;
            end
            RVC_ADDI, RVC_SLLI: begin
                regs_o.rd  = r_hi;
                regs_o.rs1 = r_hi;
            end
            RVC_LI, RVC_LUI: regs_o.rd = r_hi;  // LI adds to x0
            RVC_JAL:         regs_o.rd = `RV_REG_RA;
            RVC_ADDI16SP: begin
                regs_o.rd  = `RV_REG_SP;
                regs_o.rs1 = `RV_REG_SP;
            end
            RVC_SRLI, RVC_SRAI, RVC_ANDI: begin
                regs_o.rd  = rp_hi;
                regs_o.rs1 = rp_hi;
            end
            RVC_SUB, RVC_XOR, RVC_OR, RVC_AND: begin
                regs_o.rd  = rp_hi;
                regs_o.rs1 = rp_hi;
                regs_o.rs2 = rp_lo;
            end
            RVC_BEQZ, RVC_BNEZ: regs_o.rs1 = rp_hi; // Compare against x0
            RVC_LWSP: begin
                regs_o.rd  = r_hi;
                regs_o.rs1 = `RV_REG_SP;
            end
            RVC_SWSP: begin
                regs_o.rs1 = `RV_REG_SP;
                regs_o.rs2 = r_lo;
            end
            RVC_JR: regs_o.rs1 = r_hi;
            RVC_JALR: begin
                regs_o.rd  = `RV_REG_RA;
                regs_o.rs1 = r_hi;
            end
            RVC_MV: begin
                regs_o.rd  = r_hi;
                regs_o.rs2 = r_lo;
            end
            RVC_ADD: begin
                regs_o.rd  = r_hi;
                regs_o.rs1 = r_hi;
                regs_o.rs2 = r_lo;
            end
            default: regs_o = '0;   // J, EBREAK, illegal
        endcase
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the RV32C expander testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module tb_rvc_decompressor \
    -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS PASSED" sim.log; then
    exit 0
fi
exit 1

// File: include/rvc_ref_model.svh
// ------------------------------------------------
// Reference RV32C expander for the testbench
// Returns {illegal, word}, word unspecified if illegal
// ------------------------------------------------
`ifndef RVC_REF_MODEL_SVH
`define RVC_REF_MODEL_SVH

function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] encode_s(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [6:0] opc);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
endfunction

function automatic logic [31:0] encode_b(input logic [12:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3);
    return {imm[12], imm[10:5], 5'd0, rs1, f3, imm[4:1], imm[11], 7'h63};
endfunction

function automatic logic [31:0] encode_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
endfunction

function automatic logic [32:0] decompress_ref(input logic [15:0] c);
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [4:0]  rdp;     // Primed field at 9:7
    logic [4:0]  rsp;     // Primed field at 4:2
    logic [11:0] imm6;
    logic [9:0]  nzuimm;
    logic [6:0]  woff;
    logic [7:0]  lwsp;
    logic [7:0]  swsp;
    logic [9:0]  sp16;
    logic [11:0] joff;
    logic [8:0]  boff;
    logic        ill;
    logic [31:0] w;
    rd     = c[11:7];
    rs2    = c[6:2];
    rdp    = {`RVC_RPRIME_BASE, c[9:7]};
    rsp    = {`RVC_RPRIME_BASE, c[4:2]};
    imm6   = {{6{c[12]}}, c[12], c[6:2]};
    nzuimm = {c[10:7], c[12:11], c[5], c[6], 2'b00};
    woff   = {c[5], c[12:10], c[6], 2'b00};
    lwsp   = {c[3:2], c[12], c[6:4], 2'b00};
    swsp   = {c[8:7], c[12:9], 2'b00};
    sp16   = {c[12], c[4:3], c[5], c[2], c[6], 4'b0000};
    joff   = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
    boff   = {c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};
    ill    = 1'b0;
    w      = '0;
    case ({c[1:0], c[15:13]})
        5'b00000: begin
            ill = (c[12:5] == 8'd0);
            w   = encode_i({2'b00, nzuimm}, `RV_REG_SP, 3'd0, rsp, 7'h13);
        end
        5'b00010: w = encode_i({5'd0, woff}, rdp, 3'd2, rsp, 7'h03);
        5'b00110: w = encode_s({5'd0, woff}, rsp, rdp, 3'd2, 7'h23);
        5'b01000: w = encode_i(imm6, rd, 3'd0, rd, 7'h13);
        5'b01001: w = encode_j({{9{joff[11]}}, joff}, `RV_REG_RA);
        5'b01010: w = encode_i(imm6, 5'd0, 3'd0, rd, 7'h13);
        5'b01011: begin
            ill = ({c[12], c[6:2]} == 6'd0);
            if (rd == `RV_REG_SP)
                w = encode_i({{2{sp16[9]}}, sp16}, `RV_REG_SP, 3'd0, `RV_REG_SP, 7'h13);
            else
                w = {{14{c[12]}}, c[12], c[6:2], rd, 7'h37};
        end
        5'b01100: begin
            ill = c[12] && (c[11:10] != 2'b10);
            case (c[11:10])
                2'b00: w = encode_i({7'd0, c[6:2]}, rdp, 3'd5, rdp, 7'h13);
                2'b01: w = encode_i({7'h20, c[6:2]}, rdp, 3'd5, rdp, 7'h13);
                2'b10: w = encode_i(imm6, rdp, 3'd7, rdp, 7'h13);
                default: begin
                    case (c[6:5])
                        2'b00:   w = encode_r(7'h20, rsp, rdp, 3'd0, rdp, 7'h33);
                        2'b01:   w = encode_r(7'h00, rsp, rdp, 3'd4, rdp, 7'h33);
                        2'b10:   w = encode_r(7'h00, rsp, rdp, 3'd6, rdp, 7'h33);
                        default: w = encode_r(7'h00, rsp, rdp, 3'd7, rdp, 7'h33);
                    endcase
                end
            endcase
        end
        5'b01101: w = encode_j({{9{joff[11]}}, joff}, 5'd0);
        5'b01110: w = encode_b({{4{boff[8]}}, boff}, rdp, 3'd0);
        5'b01111: w = encode_b({{4{boff[8]}}, boff}, rdp, 3'd1);
        5'b10000: begin
            ill = c[12];
            w   = encode_i({7'd0, c[6:2]}, rd, 3'd1, rd, 7'h13);
        end
        5'b10010: w = encode_i({4'd0, lwsp}, `RV_REG_SP, 3'd2, rd, 7'h03);
        5'b10100: begin
            if (!c[12] && rs2 == 5'd0)
                w = encode_i(12'd0, rd, 3'd0, 5'd0, 7'h67);            // JR
            else if (!c[12])
                w = encode_r(7'h00, rs2, 5'd0, 3'd0, rd, 7'h33);       // MV
            else if (rs2 != 5'd0)
                w = encode_r(7'h00, rs2, rd, 3'd0, rd, 7'h33);         // ADD
            else if (rd == 5'd0)
                w = 32'h0010_0073;                                     // EBREAK
            else
                w = encode_i(12'd0, rd, 3'd0, `RV_REG_RA, 7'h67);      // JALR
        end
        5'b10110: w = encode_s({4'd0, swsp}, rs2, `RV_REG_SP, 3'd2, 7'h23);
        default:  ill = 1'b1;   // FP forms, reserved slots, quadrant 3
    endcase
    return {ill, w};
endfunction

`endif

// File: tb/tb_rvc_decompressor.sv
// ------------------------------------------------
// Self-checking testbench for the RV32C expander
// Word is compared only for legal results
// ------------------------------------------------
`default_nettype none

`include "rvc_config.svh"

module tb_rvc_decompressor;
    import rvc_pkg::*;

    `include "rvc_ref_model.svh"

    typedef struct packed {
        logic        valid;
        logic        illegal;
        rv_instr32_t instr;
    } expect_t;

    logic         clk_i;
    logic         rst_n_i;
    logic         ci_valid_i;
    rvc_instr16_t ci_instr16_i;
    logic         ci_valid_o;
    logic         ci_illegal_o;
    rv_instr32_t  ci_instr32_o;

    expect_t     exp_q[$];
    logic [31:0] rng_state;
    int          n_in;
    int          n_out;

    rvc_decompressor UUT (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .ci_valid_i   (ci_valid_i),
        .ci_instr16_i (ci_instr16_i),
        .ci_valid_o   (ci_valid_o),
        .ci_illegal_o (ci_illegal_o),
        .ci_instr32_o (ci_instr32_o)
    );

    always #5 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Checks
    // ------------------------------------------------
    task automatic report_failure();
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_illegal(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("mismatch %s got %h expected %h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_valid(input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch ci_valid_o got %h expected %h", got, exp);
            report_failure();
        end
    endtask

    task automatic check_instr(input rv_instr32_t got, input rv_instr32_t exp);
        if (got !== exp) begin
            $display("mismatch ci_instr32_o got %h expected %h", got, exp);
            report_failure();
        end
    endtask

    // Stimulus
    // ------------------------------------------------
    task automatic drive_cycle(input logic vld, input rvc_instr16_t word);
        expect_t     e;
        logic [32:0] r;
        @(posedge clk_i);
        #1;
        ci_valid_i   = vld;
        ci_instr16_i = word;
        r            = decompress_ref(word);
        e.valid      = vld;
        e.illegal    = r[32];
        e.instr      = r[31:0];
        exp_q.push_back(e);
        if (vld) n_in++;
    endtask

    task automatic send_reserved(input rvc_instr16_t word);
        logic [32:0] r;
        r = decompress_ref(word);
        if (!r[32]) begin
            $display("reserved encoding %h is not flagged by the reference", word);
            report_failure();
        end
        drive_cycle(1'b1, word);
    endtask

    task automatic send_random(input int count, input logic with_gaps);
        logic vld;
        for (int i = 0; i < count; i++) begin
            rng_state = xorshift32(rng_state);
            vld       = with_gaps ? rng_state[20] : 1'b1;
            drive_cycle(vld, rng_state[15:0]);
        end
    endtask

    // Output compare, one entry per driven cycle
    initial begin
        expect_t e;
        forever begin
            @(negedge clk_i);
            if (ci_valid_o === 1'b1) n_out++;
            if (exp_q.size() >= 2) begin
                e = exp_q.pop_front();
                check_valid(ci_valid_o, e.valid);
                if (e.valid) begin
                    check_illegal(ci_illegal_o, e.illegal, "ci_illegal_o");
                    if (!e.illegal) check_instr(ci_instr32_o, e.instr);
                end
            end
        end
    end

    initial begin
        int wait_cnt;
        clk_i        = 1'b0;
        rst_n_i      = 1'b0;
        ci_valid_i   = 1'b0;
        ci_instr16_i = '0;
        rng_state    = 32'd11;
        n_in         = 0;
        n_out        = 0;

        repeat (16) begin
            @(negedge clk_i);
            check_valid(ci_valid_o, 1'b0);
            check_illegal(ci_illegal_o, 1'b0, "ci_illegal_o");
        end
        @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        drive_cycle(1'b0, '0);
        @(negedge clk_i);
        check_valid(ci_valid_o, 1'b0);
        check_illegal(ci_illegal_o, 1'b0, "ci_illegal_o");

        // Directed, every kept instruction
        drive_cycle(1'b1, {3'b000, 8'b10110101, 3'b011, 2'b00});         // ADDI4SPN
        drive_cycle(1'b1, {3'b010, 3'b101, 3'b010, 2'b11, 3'b100, 2'b00}); // LW
        drive_cycle(1'b1, {3'b110, 3'b011, 3'b110, 2'b01, 3'b111, 2'b00}); // SW
        drive_cycle(1'b1, 16'h0001);                                       // NOP
        drive_cycle(1'b1, {3'b000, 1'b0, 5'd9, 5'd7, 2'b01});
        drive_cycle(1'b1, {3'b000, 1'b1, 5'd12, 5'd3, 2'b01});
        drive_cycle(1'b1, {3'b001, 11'h2a5, 2'b01});                       // JAL
        drive_cycle(1'b1, {3'b001, 11'h5c3, 2'b01});
        drive_cycle(1'b1, {3'b010, 1'b1, 5'd10, 5'b10110, 2'b01});         // LI
        drive_cycle(1'b1, {3'b010, 1'b0, 5'd5, 5'd17, 2'b01});
        drive_cycle(1'b1, {3'b011, 1'b1, 5'd2, 5'b01101, 2'b01});          // ADDI16SP
        drive_cycle(1'b1, {3'b011, 1'b0, 5'd2, 5'b10010, 2'b01});
        drive_cycle(1'b1, {3'b011, 1'b0, 5'd15, 5'd6, 2'b01});             // LUI
        drive_cycle(1'b1, {3'b011, 1'b1, 5'd20, 5'd1, 2'b01});
        drive_cycle(1'b1, {3'b100, 1'b0, 2'b00, 3'd3, 5'd13, 2'b01});      // SRLI
        drive_cycle(1'b1, {3'b100, 1'b0, 2'b01, 3'd6, 5'd31, 2'b01});      // SRAI
        drive_cycle(1'b1, {3'b100, 1'b1, 2'b10, 3'd2, 5'd5, 2'b01});       // ANDI
        drive_cycle(1'b1, {3'b100, 1'b0, 2'b10, 3'd7, 5'd9, 2'b01});
        drive_cycle(1'b1, {3'b100, 1'b0, 2'b11, 3'd4, 2'b00, 3'd5, 2'b01}); // SUB
        drive_cycle(1'b1, {3'b100, 1'b0, 2'b11, 3'd1, 2'b01, 3'd6, 2'b01}); // XOR
        drive_cycle(1'b1, {3'b100, 1'b0, 2'b11, 3'd2, 2'b10, 3'd3, 2'b01}); // OR
        drive_cycle(1'b1, {3'b100, 1'b0, 2'b11, 3'd7, 2'b11, 3'd0, 2'b01}); // AND
        drive_cycle(1'b1, {3'b101, 11'h3ff, 2'b01});                       // J
        drive_cycle(1'b1, {3'b101, 11'h401, 2'b01});
        drive_cycle(1'b1, {3'b110, 3'b101, 3'd1, 5'b11010, 2'b01});        // BEQZ
        drive_cycle(1'b1, {3'b111, 3'b010, 3'd7, 5'b00101, 2'b01});        // BNEZ
        drive_cycle(1'b1, {3'b000, 1'b0, 5'd18, 5'd11, 2'b10});            // SLLI
        drive_cycle(1'b1, {3'b010, 1'b1, 5'd8, 5'b10111, 2'b10});          // LWSP
        drive_cycle(1'b1, {3'b110, 6'b101011, 5'd19, 2'b10});              // SWSP
        drive_cycle(1'b1, {3'b100, 1'b0, 5'd6, 5'd0, 2'b10});              // JR
        drive_cycle(1'b1, {3'b100, 1'b0, 5'd14, 5'd21, 2'b10});            // MV
        drive_cycle(1'b1, 16'h9002);                                       // EBREAK
        drive_cycle(1'b1, {3'b100, 1'b1, 5'd25, 5'd0, 2'b10});             // JALR
        drive_cycle(1'b1, {3'b100, 1'b1, 5'd3, 5'd29, 2'b10});             // ADD

        // Reserved encodings
        send_reserved(16'h0000);
        send_reserved({3'b011, 3'b010, 3'b001, 2'b10, 3'b011, 2'b00});     // FLW
        send_reserved({3'b111, 3'b100, 3'b110, 2'b01, 3'b010, 2'b00});     // FSW
        send_reserved({3'b011, 1'b0, 5'd4, 5'd12, 2'b10});                 // FLWSP
        send_reserved({3'b111, 6'b010110, 5'd7, 2'b10});                   // FSWSP
        send_reserved({3'b011, 1'b0, 5'd7, 5'd0, 2'b01});                  // LUI zero
        send_reserved({3'b100, 1'b1, 2'b00, 3'd1, 5'd4, 2'b01});           // SRLI shamt[5]
        send_reserved({3'b000, 1'b1, 5'd9, 5'd2, 2'b10});                  // SLLI shamt[5]
        send_reserved(16'h4a5b);                                           // Quadrant 3

        send_random(2000, 1'b0);
        send_random(500, 1'b1);
        drive_cycle(1'b0, '0);

        wait_cnt = 0;
        while (exp_q.size() > 1) begin
            @(negedge clk_i);
            wait_cnt++;
            if (wait_cnt > 20) begin
                $display("timeout while waiting for the last outputs");
                report_failure();
            end
        end

        if (n_out != n_in) begin
            $display("output count %0d differs from input count %0d", n_out, n_in);
            report_failure();
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire
